//--- vst.f
+incdir+include
design/vst_pkg.sv
design/vst_elem_sequencer.sv
design/vst_store_fifo.sv
design/vst_mem_issuer.sv
design/vst_top.sv
tb/tb_vst.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the vector store engine testbench with Verilator and runs it.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal \
    --top-module tb_vst \
    -f vst.f \
    -o sim_vst \
    || { echo "Build failed"; exit 1; }

./obj_dir/sim_vst > sim.log 2>&1
cat sim.log

grep -qx "NO ERRORS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tb/tb_vst.sv
/*
  Testbench of the vector store engine, six instructions back to back.
  Checks sample at the falling edge, where all DUT outputs have settled.
*/
`timescale 1ns/1ps
`include "vst_settings.svh"

module tb_vst import vst_pkg::*; ();

    localparam int LANES           = `VST_LANES;
    localparam int DATA_W          = `VST_DATA_W;
    localparam int ADDR_W          = `VST_ADDR_W;
    localparam int VL_W            = `VST_VL_W;
    localparam int REG_W           = $clog2(`VST_VREGS);
    localparam int NUM_TESTS       = 6;
    localparam int VL_MAX          = 24;   // Longest vl used below
    localparam int GRANT_WAIT_MAX  = 6;    // Longest run of withheld grants
    localparam int GRANT_DELAY_MAX = 10;   // Worst cycles per element
    localparam int TIMEOUT_CYCLES  = NUM_TESTS * (VL_MAX + 1) * GRANT_DELAY_MAX + 1000;

    // ==============================
    // DUT signals
    // ==============================
    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      instr_valid_i;
    vst_instr_t                instr_i;
    logic                      instr_ready_o;
    logic [REG_W-1:0]          rd_addr_data_o;
    logic [REG_W-1:0]          rd_addr_idx_o;
    logic [LANES*DATA_W-1:0]   rd_data_data_i;
    logic [LANES*DATA_W-1:0]   rd_data_idx_i;
    logic                      rd_pending_data_i = 1'b0;
    logic                      rd_pending_idx_i  = 1'b0;
    logic                      grant_i           = 1'b0;
    logic                      req_en_o;
    vst_entry_t                req_entry_o;
    logic                      unlock_en_o;
    logic [REG_W-1:0]          unlock_data_reg_o;
    logic [REG_W-1:0]          unlock_idx_reg_o;
    logic                      busy_o;
    logic [ADDR_W-1:0]         start_addr_o;
    logic [ADDR_W-1:0]         end_addr_o;

    // Testbench state
    logic        rand_en    = 1'b0;   // Random stalls and grant delays
    logic [15:0] lfsr_state = 16'd60;
    int          hold_cnt   = 0;
    int          cycle_cnt  = 0;
    int          err_cnt    = 0;
    int          tests_failed = 0;
    vst_instr_t  exp_instr;
    int          grant_cnt;
    int          unlock_cnt;

    always #4 clk = ~clk;

    vst_top u_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .instr_valid_i     (instr_valid_i),
        .instr_i           (instr_i),
        .instr_ready_o     (instr_ready_o),
        .rd_addr_data_o    (rd_addr_data_o),
        .rd_addr_idx_o     (rd_addr_idx_o),
        .rd_data_data_i    (rd_data_data_i),
        .rd_data_idx_i     (rd_data_idx_i),
        .rd_pending_data_i (rd_pending_data_i),
        .rd_pending_idx_i  (rd_pending_idx_i),
        .grant_i           (grant_i),
        .req_en_o          (req_en_o),
        .req_entry_o       (req_entry_o),
        .unlock_en_o       (unlock_en_o),
        .unlock_data_reg_o (unlock_data_reg_o),
        .unlock_idx_reg_o  (unlock_idx_reg_o),
        .busy_o            (busy_o),
        .start_addr_o      (start_addr_o),
        .end_addr_o        (end_addr_o)
    );

    // ==============================
    // Reference rules
    // ==============================
    // Lane part of the index table
    function automatic logic [DATA_W-1:0] idx_offset(input int lane);
        case (lane)
            0:       return 32'h0000_0100;
            1:       return 32'h0000_0008;
            2:       return 32'h0000_0FFC;
            3:       return 32'h0000_0040;
            4:       return 32'hFFFF_FFF0;   // Negative offset
            5:       return 32'h0000_0024;
            6:       return 32'h0000_0000;
            default: return 32'h0000_1000;
        endcase
    endfunction

    // Register number lands in the upper half, so each index register differs
    function automatic logic [DATA_W-1:0] idx_entry(input logic [REG_W-1:0] r, input int lane);
        return DATA_W'(r) * 32'h0001_0000 + idx_offset(lane);
    endfunction

    function automatic logic [ADDR_W-1:0] exp_addr(input vst_instr_t ins, input int k);
        case (ins.mode)
            VST_STRIDED: return ins.base + ins.stride * ADDR_W'(k);
            VST_INDEXED: return ins.base + idx_entry(ins.idx_reg + REG_W'(k / LANES),
                                                     k % LANES);
            default:     return ins.base + ADDR_W'(k) * 32'd4;
        endcase
    endfunction

    // Element k sits in register data_reg + k/8 at lane k%8
    function automatic logic [DATA_W-1:0] exp_data(input vst_instr_t ins, input int k);
        logic [REG_W-1:0] r;
        r = ins.data_reg + REG_W'(k / LANES);
        return DATA_W'(r) * 32'd256 + DATA_W'(k % LANES);
    endfunction

    function automatic logic [ADDR_W-1:0] exp_end_addr(input vst_instr_t ins);
        if (ins.mode == VST_INDEXED) begin
            return ins.base;
        end
        if (ins.mode == VST_STRIDED) begin
            return ins.base + (ADDR_W'(ins.vl) - 1) * ins.stride;
        end
        return ins.base + (ADDR_W'(ins.vl) - 1) * 32'd4;
    endfunction

    function automatic int exp_unlocks(input vst_instr_t ins);
        return (int'(ins.vl) + LANES - 1) / LANES;
    endfunction

    function automatic vst_instr_t make_instr(input vst_mode_e mode, input logic [31:0] base,
                                              input logic [31:0] stride, input int vl,
                                              input int dreg, input int ireg);
        vst_instr_t ins;
        ins.mode     = mode;
        ins.base     = base;
        ins.stride   = stride;
        ins.vl       = VL_W'(vl);
        ins.data_reg = REG_W'(dreg);
        ins.idx_reg  = REG_W'(ireg);
        return ins;
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bit(output logic b);
        b          = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        err_cnt++;
        $display("Mismatch %s: got %h expected %h at %0t", sig, got, exp, $time);
    endtask

    task automatic report_failure(input string what);
        err_cnt++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    // ==============================
    // Register file and memory models
    // ==============================
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            rd_data_data_i[l*DATA_W +: DATA_W] = DATA_W'(rd_addr_data_o) * 32'd256 + DATA_W'(l);
            rd_data_idx_i[l*DATA_W +: DATA_W]  = idx_entry(rd_addr_idx_o, l);
        end
    end

    always @(posedge clk) begin : stim
        logic b_pd0;
        logic b_pd1;
        logic b_pi0;
        logic b_pi1;
        logic b_gnt;
        if (rand_en) begin
            draw_bit(b_pd0);
            draw_bit(b_pd1);
            draw_bit(b_pi0);
            draw_bit(b_pi1);
            draw_bit(b_gnt);
            rd_pending_data_i <= b_pd0 & b_pd1;   // Pending about a quarter of the time
            rd_pending_idx_i  <= b_pi0 & b_pi1;
            grant_i           <= b_gnt | (hold_cnt >= GRANT_WAIT_MAX);
        end else begin
            rd_pending_data_i <= 1'b0;
            rd_pending_idx_i  <= 1'b0;
            grant_i           <= 1'b1;
        end
        hold_cnt <= grant_i ? 0 : hold_cnt + 1;
    end

    // Scoreboard of the accepted instruction
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_instr  <= '0;
            grant_cnt  <= 0;
            unlock_cnt <= 0;
        end else if (instr_valid_i && instr_ready_o) begin
            exp_instr  <= instr_i;
            grant_cnt  <= 0;
            unlock_cnt <= 0;
        end else begin
            if (req_en_o && grant_i) begin
                grant_cnt <= grant_cnt + 1;
            end
            if (unlock_en_o) begin
                unlock_cnt <= unlock_cnt + 1;
            end
        end
    end

    // ==============================
    // Checks
    // ==============================
    a_grant_addr: assert property (@(negedge clk) disable iff (!rst_n)
        (req_en_o && grant_i) |-> (req_entry_o.addr == exp_addr(exp_instr, grant_cnt)))
        else report_mismatch("req_entry_o.addr", req_entry_o.addr,
                             exp_addr(exp_instr, grant_cnt));

    a_grant_data: assert property (@(negedge clk) disable iff (!rst_n)
        (req_en_o && grant_i) |-> (req_entry_o.data == exp_data(exp_instr, grant_cnt)))
        else report_mismatch("req_entry_o.data", req_entry_o.data,
                             exp_data(exp_instr, grant_cnt));

    a_grant_limit: assert property (@(negedge clk) disable iff (!rst_n)
        (req_en_o && grant_i) |-> (grant_cnt < int'(exp_instr.vl)))
        else report_failure("more requests granted than vl elements");

    a_req_hold: assert property (@(negedge clk) disable iff (!rst_n)
        (req_en_o && !grant_i) |=> (req_en_o && $stable(req_entry_o)))
        else report_failure("request dropped or changed before its grant");

    a_unlock_data: assert property (@(negedge clk) disable iff (!rst_n)
        unlock_en_o |-> (unlock_data_reg_o == exp_instr.data_reg + REG_W'(unlock_cnt)))
        else report_mismatch("unlock_data_reg_o", 32'(unlock_data_reg_o),
                             32'(exp_instr.data_reg + REG_W'(unlock_cnt)));

    a_unlock_idx: assert property (@(negedge clk) disable iff (!rst_n)
        unlock_en_o |-> (unlock_idx_reg_o == exp_instr.idx_reg + REG_W'(unlock_cnt)))
        else report_mismatch("unlock_idx_reg_o", 32'(unlock_idx_reg_o),
                             32'(exp_instr.idx_reg + REG_W'(unlock_cnt)));

    a_unlock_limit: assert property (@(negedge clk) disable iff (!rst_n)
        unlock_en_o |-> (unlock_cnt < exp_unlocks(exp_instr)))
        else report_failure("more unlock pulses than register pairs");

    a_start_addr: assert property (@(negedge clk) disable iff (!rst_n)
        busy_o |-> (start_addr_o == exp_instr.base))
        else report_mismatch("start_addr_o", start_addr_o, exp_instr.base);

    a_end_addr: assert property (@(negedge clk) disable iff (!rst_n)
        busy_o |-> (end_addr_o == exp_end_addr(exp_instr)))
        else report_mismatch("end_addr_o", end_addr_o, exp_end_addr(exp_instr));

    // Completion only after every grant and unlock
    a_done_grants: assert property (@(negedge clk) disable iff (!rst_n)
        $fell(busy_o) |-> (grant_cnt == int'(exp_instr.vl)))
        else report_mismatch("grant count", 32'(grant_cnt), 32'(exp_instr.vl));

    a_done_unlocks: assert property (@(negedge clk) disable iff (!rst_n)
        $fell(busy_o) |-> (unlock_cnt == exp_unlocks(exp_instr)))
        else report_mismatch("unlock count", 32'(unlock_cnt), 32'(exp_unlocks(exp_instr)));

    a_ready_idle: assert property (@(negedge clk) disable iff (!rst_n)
        !busy_o |-> instr_ready_o)
        else report_failure("instr_ready_o low while the engine is idle");

    // ==============================
    // Sequencing and timeout
    // ==============================
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT did not finish", cycle_cnt);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic run_test(input int num, input string name, input vst_instr_t ins,
                            input logic rnd);
        int err_before;
        err_before = err_cnt;
        rand_en <= rnd;
        @(posedge clk);
        while (!instr_ready_o) @(posedge clk);
        instr_valid_i <= 1'b1;
        instr_i       <= ins;
        @(posedge clk);                        // Transfer edge
        instr_valid_i <= 1'b0;
        @(posedge clk);
        while (busy_o) @(posedge clk);
        if (err_cnt == err_before) begin
            $display("Test %0d %s: pass", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: fail, %0d errors", num, name, err_cnt - err_before);
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        run_test(1, "unit vl 8", make_instr(VST_UNIT, 32'h1000_0000, 32'h0, 8, 2, 0), 1'b0);
        run_test(2, "strided vl 20",
                 make_instr(VST_STRIDED, 32'h2000_0040, 32'h10, 20, 5, 0), 1'b0);
        run_test(3, "indexed vl 8",
                 make_instr(VST_INDEXED, 32'h3000_0000, 32'h0, 8, 9, 4), 1'b0);
        run_test(4, "unit vl 17 with stalls",
                 make_instr(VST_UNIT, 32'h4000_0100, 32'h0, 17, 20, 0), 1'b1);
        run_test(5, "strided vl 24 negative stride with stalls",
                 make_instr(VST_STRIDED, 32'h5000_1000, 32'hFFFF_FFF4, VL_MAX, 12, 0), 1'b1);
        run_test(6, "indexed vl 12 register wrap with stalls",
                 make_instr(VST_INDEXED, 32'h6000_0800, 32'h0, 12, 31, 6), 1'b1);

        $display("Tests run %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- design/vst_top.sv
/*
  Vector store engine top: sequencer, store FIFO and memory issuer.
  One instruction at a time; done when busy_o falls.
*/
`timescale 1ns/1ps
`include "vst_settings.svh"

module vst_top import vst_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n,
    // Instruction
    input  logic                                instr_valid_i,
    input  vst_instr_t                          instr_i,
    output logic                                instr_ready_o,
    // Register file
    output logic [$clog2(`VST_VREGS)-1:0]       rd_addr_data_o,
    output logic [$clog2(`VST_VREGS)-1:0]       rd_addr_idx_o,
    input  logic [`VST_LANES*`VST_DATA_W-1:0]   rd_data_data_i,
    input  logic [`VST_LANES*`VST_DATA_W-1:0]   rd_data_idx_i,
    input  logic                                rd_pending_data_i,
    input  logic                                rd_pending_idx_i,
    // Memory
    input  logic                                grant_i,
    output logic                                req_en_o,
    output vst_entry_t                          req_entry_o,
    // Unlock
    output logic                                unlock_en_o,
    output logic [$clog2(`VST_VREGS)-1:0]       unlock_data_reg_o,
    output logic [$clog2(`VST_VREGS)-1:0]       unlock_idx_reg_o,
    // Status
    output logic                                busy_o,
    output logic [`VST_ADDR_W-1:0]              start_addr_o,
    output logic [`VST_ADDR_W-1:0]              end_addr_o
);

    // ==============================
    // Internal links
    // ==============================
    logic       push;
    vst_entry_t push_entry;
    logic       fifo_full;
    logic       fifo_empty;
    vst_entry_t fifo_head;
    logic       pop;
    logic       issuer_idle;

    vst_elem_sequencer u_seq (
        .clk               (clk),
        .rst_n             (rst_n),
        .instr_valid_i     (instr_valid_i),
        .instr_i           (instr_i),
        .instr_ready_o     (instr_ready_o),
        .rd_addr_data_o    (rd_addr_data_o),
        .rd_addr_idx_o     (rd_addr_idx_o),
        .rd_data_data_i    (rd_data_data_i),
        .rd_data_idx_i     (rd_data_idx_i),
        .rd_pending_data_i (rd_pending_data_i),
        .rd_pending_idx_i  (rd_pending_idx_i),
        .push_o            (push),
        .push_entry_o      (push_entry),
        .fifo_full_i       (fifo_full),
        .fifo_empty_i      (fifo_empty),
        .issuer_idle_i     (issuer_idle),
        .unlock_en_o       (unlock_en_o),
        .unlock_data_reg_o (unlock_data_reg_o),
        .unlock_idx_reg_o  (unlock_idx_reg_o),
        .busy_o            (busy_o),
        .start_addr_o      (start_addr_o),
        .end_addr_o        (end_addr_o)
    );

    vst_store_fifo u_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_i       (push),
        .push_entry_i (push_entry),
        .full_o       (fifo_full),
        .pop_i        (pop),
        .head_o       (fifo_head),
        .empty_o      (fifo_empty)
    );

    vst_mem_issuer u_issuer (
        .clk         (clk),
        .rst_n       (rst_n),
        .head_i      (fifo_head),
        .empty_i     (fifo_empty),
        .pop_o       (pop),
        .grant_i     (grant_i),
        .req_en_o    (req_en_o),
        .req_entry_o (req_entry_o),
        .idle_o      (issuer_idle)
    );

endmodule

//--- design/vst_mem_issuer.sv
/*
  Holds one memory write request until it is granted.
  A new entry is loaded only in the cycle after the grant.
*/
`timescale 1ns/1ps

module vst_mem_issuer import vst_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    // FIFO head
    input  vst_entry_t head_i,
    input  logic       empty_i,
    output logic       pop_o,
    // Memory request/grant
    input  logic       grant_i,
    output logic       req_en_o,
    output vst_entry_t req_entry_o,
    // Drain status
    output logic       idle_o
);

    // ==============================
    // Request register
    // ==============================
    logic       req_valid_r;
    vst_entry_t req_entry_r;

    assign pop_o = ~req_valid_r & ~empty_i;   // Free and something waiting

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid_r <= 1'b0;
        end else if (pop_o) begin
            req_valid_r <= 1'b1;
        end else if (req_valid_r && grant_i) begin
            req_valid_r <= 1'b0;
        end
    end

    // Payload only changes on a load
    always_ff @(posedge clk) begin
        if (pop_o) begin
            req_entry_r <= head_i;
        end
    end

    assign req_en_o    = req_valid_r;
    assign req_entry_o = req_entry_r;
    assign idle_o      = ~req_valid_r;

    // ==============================
    // Checks
    // ==============================
    // Request held steady while the memory withholds the grant
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (req_en_o && !grant_i) |=> (req_en_o && $stable(req_entry_o)));

endmodule

//--- design/vst_store_fifo.sv
/*
  Store entry FIFO, synchronous, no bypass.
  A push appears at the head one cycle later; depth must be a power of two.
*/
`timescale 1ns/1ps
`include "vst_settings.svh"

module vst_store_fifo import vst_pkg::*; #(
    parameter int DEPTH = `VST_FIFO_DEPTH
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push_i,
    input  vst_entry_t push_entry_i,
    output logic       full_o,
    input  logic       pop_i,
    output vst_entry_t head_o,
    output logic       empty_o
);

    localparam int PTR_W = $clog2(DEPTH);

    // ==============================
    // Storage and pointers
    // ==============================
    vst_entry_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_r;
    logic [PTR_W-1:0] rd_ptr_r;
    logic [PTR_W:0]   count_r;   // Occupancy, 0 to DEPTH

    assign full_o  = (count_r == (PTR_W+1)'(DEPTH));
    assign empty_o = (count_r == '0);
    assign head_o  = mem[rd_ptr_r];

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_r] <= push_entry_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;   // Wraps at DEPTH
            end
            if (pop_i) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;   // Both or neither
            endcase
        end
    end

    // ==============================
    // Checks
    // ==============================
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push_i |-> !full_o);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop_i |-> !empty_o);

endmodule

//--- design/vst_elem_sequencer.sv
/*
  Breaks one vector store into element entries, one per cycle at most.
  Registers are walked upwards from data_reg and idx_reg; vl of 0 is accepted and stores nothing.
*/
`timescale 1ns/1ps
`include "vst_settings.svh"

module vst_elem_sequencer import vst_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n,
    // Instruction handshake
    input  logic                                instr_valid_i,
    input  vst_instr_t                          instr_i,
    output logic                                instr_ready_o,
    // Register file read ports
    output logic [$clog2(`VST_VREGS)-1:0]       rd_addr_data_o,
    output logic [$clog2(`VST_VREGS)-1:0]       rd_addr_idx_o,
    input  logic [`VST_LANES*`VST_DATA_W-1:0]   rd_data_data_i,
    input  logic [`VST_LANES*`VST_DATA_W-1:0]   rd_data_idx_i,
    input  logic                                rd_pending_data_i,
    input  logic                                rd_pending_idx_i,
    // Store FIFO
    output logic                                push_o,
    output vst_entry_t                          push_entry_o,
    input  logic                                fifo_full_i,
    // Drain status of the downstream blocks
    input  logic                                fifo_empty_i,
    input  logic                                issuer_idle_i,
    // Register unlock
    output logic                                unlock_en_o,
    output logic [$clog2(`VST_VREGS)-1:0]       unlock_data_reg_o,
    output logic [$clog2(`VST_VREGS)-1:0]       unlock_idx_reg_o,
    // Status
    output logic                                busy_o,
    output logic [`VST_ADDR_W-1:0]              start_addr_o,
    output logic [`VST_ADDR_W-1:0]              end_addr_o
);

    localparam int LANES  = `VST_LANES;
    localparam int DATA_W = `VST_DATA_W;
    localparam int ADDR_W = `VST_ADDR_W;
    localparam int VL_W   = `VST_VL_W;
    localparam int PTR_W  = $clog2(`VST_LANES);
    localparam int REG_W  = $clog2(`VST_VREGS);

    // ==============================
    // State
    // ==============================
    logic                 active_r;     // Elements still to push
    vst_mode_e            mode_r;
    logic [ADDR_W-1:0]    base_r;
    logic [ADDR_W-1:0]    step_r;       // Byte step for unit and strided modes
    logic [VL_W-1:0]      vl_r;
    logic [REG_W-1:0]     data_reg_r;
    logic [REG_W-1:0]     idx_reg_r;
    logic [PTR_W-1:0]     elem_ptr_r;   // Lane within the current register
    logic [REG_W-1:0]     loop_cnt_r;   // Registers already finished
    logic [ADDR_W-1:0]    cur_addr_r;   // Running address, unit and strided
    logic                 unlock_en_r;
    logic [REG_W-1:0]     unlock_data_reg_r;
    logic [REG_W-1:0]     unlock_idx_reg_r;
    logic [ADDR_W-1:0]    start_addr_r;
    logic [ADDR_W-1:0]    end_addr_r;

    logic                 accept;
    logic                 need_idx;
    logic                 can_push;
    logic                 last_elem;
    logic                 reg_done;
    logic [DATA_W-1:0]    lane_data;
    logic [DATA_W-1:0]    lane_offset;
    logic [ADDR_W-1:0]    elem_addr;
    logic [ADDR_W-1:0]    nxt_step;
    logic [VL_W-1:0]      nxt_vl_m1;

    // ==============================
    // Control and handshake
    // ==============================
    // Busy until the last element has left the issuer
    assign busy_o        = active_r | ~fifo_empty_i | ~issuer_idle_i;
    assign instr_ready_o = ~busy_o;
    assign accept        = instr_valid_i & instr_ready_o;

    assign need_idx  = (mode_r == VST_INDEXED);
    assign can_push  = active_r & ~fifo_full_i & ~rd_pending_data_i
                     & ~(need_idx & rd_pending_idx_i);
    assign last_elem = (VL_W'({loop_cnt_r, elem_ptr_r}) == vl_r - 1'b1);
    assign reg_done  = last_elem | (elem_ptr_r == PTR_W'(LANES - 1));  // Pair fully read

    // ==============================
    // Element data and address
    // ==============================
    assign lane_data   = rd_data_data_i[elem_ptr_r*DATA_W +: DATA_W];
    assign lane_offset = rd_data_idx_i[elem_ptr_r*DATA_W +: DATA_W];

    always_comb begin
        case (mode_r)
            VST_INDEXED: elem_addr = base_r + lane_offset;
            default:     elem_addr = cur_addr_r;
        endcase
    end

    assign push_o            = can_push;
    assign push_entry_o.addr = elem_addr;
    assign push_entry_o.data = lane_data;

    assign rd_addr_data_o = data_reg_r;
    assign rd_addr_idx_o  = idx_reg_r;

    // Step and end address of an incoming instruction
    assign nxt_step  = (instr_i.mode == VST_STRIDED) ? instr_i.stride : ADDR_W'(`VST_ELEM_BYTES);
    assign nxt_vl_m1 = instr_i.vl - 1'b1;

    // ==============================
    // Sequencing
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_r   <= 1'b0;
            mode_r     <= VST_UNIT;
            vl_r       <= '0;
            data_reg_r <= '0;
            idx_reg_r  <= '0;
            elem_ptr_r <= '0;
            loop_cnt_r <= '0;
        end else if (accept) begin
            active_r   <= (instr_i.vl != '0);
            mode_r     <= instr_i.mode;
            vl_r       <= instr_i.vl;
            data_reg_r <= instr_i.data_reg;
            idx_reg_r  <= instr_i.idx_reg;
            elem_ptr_r <= '0;
            loop_cnt_r <= '0;
        end else if (can_push) begin
            if (last_elem) begin
                active_r <= 1'b0;
            end else if (reg_done) begin
                // Move on to the next register pair
                elem_ptr_r <= '0;
                loop_cnt_r <= loop_cnt_r + 1'b1;
                data_reg_r <= data_reg_r + 1'b1;
                idx_reg_r  <= idx_reg_r + 1'b1;
            end else begin
                elem_ptr_r <= elem_ptr_r + 1'b1;
            end
        end
    end

    // Operands and running address
    always_ff @(posedge clk) begin
        if (accept) begin
            base_r     <= instr_i.base;
            step_r     <= nxt_step;
            cur_addr_r <= instr_i.base;
        end else if (can_push) begin
            cur_addr_r <= cur_addr_r + step_r;
        end
    end

    // ==============================
    // Unlock and status
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            unlock_en_r <= 1'b0;
        end else begin
            unlock_en_r <= can_push & reg_done;  // One pulse per pair
        end
    end

    always_ff @(posedge clk) begin
        if (can_push && reg_done) begin
            unlock_data_reg_r <= data_reg_r;
            unlock_idx_reg_r  <= idx_reg_r;
        end
    end

    assign unlock_en_o       = unlock_en_r;
    assign unlock_data_reg_o = unlock_data_reg_r;
    assign unlock_idx_reg_o  = unlock_idx_reg_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_addr_r <= '0;
            end_addr_r   <= '0;
        end else if (accept) begin
            start_addr_r <= instr_i.base;
            if (instr_i.mode == VST_INDEXED || instr_i.vl == '0) begin
                end_addr_r <= instr_i.base;  // Offsets unknown up front
            end else begin
                end_addr_r <= instr_i.base + ADDR_W'(nxt_vl_m1) * nxt_step;
            end
        end
    end

    assign start_addr_o = start_addr_r;
    assign end_addr_o   = end_addr_r;

    // ==============================
    // Checks
    // ==============================
    // Element position never runs past vl
    a_elem_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        active_r |-> (VL_W'({loop_cnt_r, elem_ptr_r}) < vl_r));

    a_unlock_busy: assert property (@(posedge clk) disable iff (!rst_n)
        unlock_en_o |-> busy_o);

endmodule

//--- design/vst_pkg.sv
/*
  Shared types of the vector store engine.
  Every store entry is one 32-bit element at one byte address.
*/
`include "vst_settings.svh"

package vst_pkg;

    // ==============================
    // Addressing modes
    // ==============================
    typedef enum logic [1:0] {
        VST_UNIT    = 2'd0,  // Base plus ELEM_BYTES per element
        VST_STRIDED = 2'd1,  // Base plus stride per element
        VST_INDEXED = 2'd2   // Base plus lane offset of the index register
    } vst_mode_e;

    // ==============================
    // Instruction and store entry
    // ==============================
    typedef struct packed {
        vst_mode_e                     mode;
        logic [`VST_ADDR_W-1:0]        base;
        logic [`VST_ADDR_W-1:0]        stride;     // Ignored outside strided mode
        logic [`VST_VL_W-1:0]          vl;         // Element count, 0 stores nothing
        logic [$clog2(`VST_VREGS)-1:0] data_reg;   // First source data register
        logic [$clog2(`VST_VREGS)-1:0] idx_reg;    // First index register
    } vst_instr_t;

    // One single-element write request
    typedef struct packed {
        logic [`VST_ADDR_W-1:0] addr;
        logic [`VST_DATA_W-1:0] data;
    } vst_entry_t;

endpackage

//--- include/vst_settings.svh
/*
  Sizes and depths of the vector store engine.
  VST_VL_W must hold VST_VREGS * VST_LANES, and the FIFO depth must be a power of two.
*/
`ifndef VST_SETTINGS_SVH
`define VST_SETTINGS_SVH

// ==============================
// Vector register file geometry
// ==============================
`define VST_LANES       8   // Elements per vector register
`define VST_DATA_W      32  // Element width in bits
`define VST_VREGS       32  // Architectural vector registers
`define VST_VL_W        9   // Up to VREGS*LANES elements

// ==============================
// Memory side
// ==============================
`define VST_ADDR_W      32
`define VST_ELEM_BYTES  4   // Unit-strided byte step
`define VST_FIFO_DEPTH  4   // Store entries between sequencer and issuer

`endif
